// File: verif/st_bus_patterns.txt
# byte_addr rw fc cfg region io_dev dtack, all hex
# cfg: 2:0 mem_size 3 ste 4 mste 5 steroids 6 blitter 7 ethernec
000000 1 5 03 2 0 1
000004 1 5 03 2 0 1
000400 1 5 03 1 0 1
3ffffe 1 5 00 1 0 1
100000 0 5 01 1 0 1
200000 1 5 02 1 0 1
400000 1 5 03 0 0 0
400000 1 5 04 1 0 1
7ffffe 1 5 05 1 0 1
800000 1 5 04 0 0 0
800000 1 5 05 1 0 1
dffffe 1 5 05 1 0 1
e00000 1 5 05 4 0 1
e3fffe 1 5 03 4 0 1
e00000 0 5 03 4 0 0
e80000 1 5 03 0 0 0
e80000 1 5 23 1 0 1
fc0000 1 5 03 3 0 1
fefffe 1 5 03 3 0 1
fc0000 0 5 03 3 0 0
fa0000 1 5 03 5 0 1
fa0000 1 5 83 0 c 1
fa0000 0 5 83 0 0 0
ff8000 1 5 03 6 1 1
ff8200 1 5 03 6 2 1
ff8600 1 5 03 6 3 1
ff8800 1 5 03 6 4 1
ff8900 1 5 03 6 0 0
ff8900 1 5 0b 6 5 1
ff8a00 1 5 03 6 0 0
ff8a00 1 5 43 6 6 1
ff8a00 1 5 0b 6 6 1
ff8e00 1 5 0b 6 0 0
ff8e00 1 5 1b 6 7 1
ff8e20 1 5 1b 6 8 1
ff8e00 1 5 3b 6 0 0
ff9200 1 5 03 6 0 0
ff9200 1 5 0b 6 9 1
fffa00 1 5 03 6 a 1
fffc00 1 5 03 6 b 1
ff0000 1 5 03 6 0 0

// File: project.f
source/st_bus_pkg.sv
source/bus_slot_sequencer.sv
source/address_decoder.sv
source/bus_monitor.sv
source/irq_controller.sv
source/st_bus_top.sv
verif/tb_st_bus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_st_bus -f project.f -o tb_st_bus_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_st_bus_sim > sim.log 2>&1
cat sim.log
test -s sim.log && ! grep -q "Simulation failed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/tb_st_bus.sv
// self-checking testbench; needs verif/st_bus_patterns.txt readable from the project root, single clk_8 domain
`default_nettype none
`timescale 1ns/1ns

module tb_st_bus;

	import st_bus_pkg::*;

	localparam int MAX_PATTERNS = 64;

	logic       clk_8;
	logic       pll_locked;
	mem_size_t  mem_size;
	logic       ste, mste, steroids, blitter_en, ethernec_en, enable_16mhz;
	logic [23:1] cpu_addr;
	logic       cpu_rw;
	logic [2:0] cpu_fc;
	logic       cpu_as, cpu_fast_cycle, clr_berr, br;
	logic       st_hs, st_vs, mfp_irq;

	logic       cpu_cycle, video_cycle, cpu2mem, dtack, berr, mfp_iack;
	region_t    region;
	io_dev_t    io_dev;
	logic [2:0] ipl;
	logic [7:0] auto_vector;

	// one access per entry, loaded from the pattern file
	logic [23:0] pat_addr [MAX_PATTERNS];
	logic        pat_rw [MAX_PATTERNS];
	logic [2:0]  pat_fc [MAX_PATTERNS];
	logic [7:0]  pat_cfg [MAX_PATTERNS];
	logic [2:0]  pat_region [MAX_PATTERNS];
	logic [3:0]  pat_io [MAX_PATTERNS];
	logic        pat_dtack [MAX_PATTERNS];

	int     pattern_count;
	int     errors;
	int     checks;
	int     cycle_count;
	int     cycle_limit;
	integer seed;
	bit     file_ok;

	st_bus_top u_st_bus_top (
		.clk_8          (clk_8),
		.pll_locked     (pll_locked),
		.mem_size       (mem_size),
		.ste            (ste),
		.mste           (mste),
		.steroids       (steroids),
		.blitter_en     (blitter_en),
		.ethernec_en    (ethernec_en),
		.enable_16mhz   (enable_16mhz),
		.cpu_addr       (cpu_addr),
		.cpu_rw         (cpu_rw),
		.cpu_fc         (cpu_fc),
		.cpu_as         (cpu_as),
		.cpu_fast_cycle (cpu_fast_cycle),
		.clr_berr       (clr_berr),
		.br             (br),
		.st_hs          (st_hs),
		.st_vs          (st_vs),
		.mfp_irq        (mfp_irq),
		.cpu_cycle      (cpu_cycle),
		.video_cycle    (video_cycle),
		.region         (region),
		.io_dev         (io_dev),
		.cpu2mem        (cpu2mem),
		.dtack          (dtack),
		.berr           (berr),
		.ipl            (ipl),
		.auto_vector    (auto_vector),
		.mfp_iack       (mfp_iack)
	);

	always #2 clk_8 = ~clk_8;

	// run limit, armed once the pattern count is known
	always @(posedge clk_8) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("run stopped: no progress after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// cfg bits: 2:0 mem_size, 3 ste, 4 mste, 5 steroids, 6 blitter, 7 ethernec
	task automatic set_config(input logic [7:0] cfg, input logic en16);
		mem_size     <= mem_size_t'(cfg[2:0]);
		ste          <= cfg[3];
		mste         <= cfg[4];
		steroids     <= cfg[5];
		blitter_en   <= cfg[6];
		ethernec_en  <= cfg[7];
		enable_16mhz <= en16;
	endtask

	task automatic read_patterns(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [23:0] a;
		logic [7:0]  rw, fc, cfg, rg, io, dt;
		fd = $fopen("verif/st_bus_patterns.txt", "r");
		ok = 0;
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// comment lines fail the scan and drop out here
				if (n > 0 && pattern_count < MAX_PATTERNS &&
					$sscanf(line, "%h %h %h %h %h %h %h", a, rw, fc, cfg, rg, io, dt) == 7) begin
					pat_addr[pattern_count]   = a;
					pat_rw[pattern_count]     = rw[0];
					pat_fc[pattern_count]     = fc[2:0];
					pat_cfg[pattern_count]    = cfg;
					pat_region[pattern_count] = rg[2:0];
					pat_io[pattern_count]     = io[3:0];
					pat_dtack[pattern_count]  = dt[0];
					pattern_count++;
				end
			end
			$fclose(fd);
			ok = (pattern_count > 0);
		end
	endtask

	// caller sits on a falling edge
	task automatic wait_cpu_slot;
		while (!cpu_cycle)
			@(negedge clk_8);
	endtask

	task automatic check_slots(input logic [7:0] cfg, input logic en16, input int exp_cpu);
		int videos;
		int cpus;
		bit prev_video;
		videos = 0;
		cpus = 0;
		prev_video = 0;
		@(posedge clk_8);
		set_config(cfg, en16);
		repeat (8) begin
			@(negedge clk_8);
			if (video_cycle)
				videos++;
			if (cpu_cycle)
				cpus++;
			check(video_cycle && cpu_cycle, 0, "video and cpu slot overlap");
			// the cpu slot always follows the video slot
			if (prev_video)
				check(cpu_cycle, 1, "cpu slot after video slot");
			prev_video = video_cycle;
		end
		check(videos, 2, "video slots in 8 cycles");
		check(cpus, exp_cpu, "cpu slots in 8 cycles");
	endtask

	task automatic run_pattern(input int i);
		logic exp_mem;
		// ram both ways, rom regions only on read
		exp_mem = (pat_region[i] == 3'd1) ||
			(pat_rw[i] && pat_region[i] >= 3'd2 && pat_region[i] <= 3'd5);
		@(posedge clk_8);
		cpu_addr <= pat_addr[i][23:1];
		cpu_rw   <= pat_rw[i];
		cpu_fc   <= pat_fc[i];
		cpu_as   <= 1'b1;
		br       <= 1'b0;
		set_config(pat_cfg[i], 1'b0);
		repeat (2) @(posedge clk_8);
		@(negedge clk_8);
		check(region, pat_region[i], $sformatf("region at %h", pat_addr[i]));
		check(io_dev, pat_io[i], $sformatf("io_dev at %h", pat_addr[i]));
		check(cpu2mem, exp_mem, $sformatf("cpu2mem at %h", pat_addr[i]));
		wait_cpu_slot();
		@(negedge clk_8);
		check(dtack, pat_dtack[i], $sformatf("dtack at %h", pat_addr[i]));
		// same access with another master on the bus
		@(posedge clk_8);
		br <= 1'b1;
		@(negedge clk_8);
		wait_cpu_slot();
		@(negedge clk_8);
		check(dtack, 0, $sformatf("dtack with br at %h", pat_addr[i]));
	endtask

	task automatic run_berr_test;
		int          slots;
		int          waited;
		bit          seen;
		logic [23:0] ra;
		slots = 0;
		waited = 0;
		seen = 0;
		@(posedge clk_8);
		cpu_as <= 1'b0;
		br <= 1'b0;
		cpu_fast_cycle <= 1'b0;
		cpu_rw <= 1'b1;
		cpu_fc <= 3'd5;
		cpu_addr <= 23'h7f8000;
		set_config(8'h03, 1'b0);
		repeat (3) @(posedge clk_8);
		clr_berr <= 1'b1;
		@(posedge clk_8);
		clr_berr <= 1'b0;
		cpu_as <= 1'b1;
		while (!seen && waited < 4 * BERR_LIMIT + 4) begin
			// unmapped io page below the mmu register
			ra = 24'hff0000 | (24'($random(seed)) & 24'h007ffe);
			cpu_addr <= ra[23:1];
			@(negedge clk_8);
			if (berr) begin
				seen = 1;
				if (slots < BERR_LIMIT) begin
					errors++;
					$display("ERR %0t: berr after only %0d cpu slots", $time, slots);
				end
			end else if (cpu_cycle) begin
				slots++;
			end
			waited++;
			@(posedge clk_8);
		end
		checks++;
		if (!seen) begin
			errors++;
			$display("bus error never raised on an unmapped io address");
		end
		cpu_as <= 1'b0;
		clr_berr <= 1'b1;
		@(posedge clk_8);
		clr_berr <= 1'b0;
		@(negedge clk_8);
		check(berr, 0, "berr after clr_berr");
	endtask

	task automatic pulse_sync(input logic vs, input logic hs);
		@(posedge clk_8);
		st_vs <= vs;
		st_hs <= hs;
		repeat (2) @(posedge clk_8);
		st_vs <= 1'b0;
		st_hs <= 1'b0;
	endtask

	task automatic wait_ipl(input logic [2:0] exp, input string what);
		int n;
		n = 0;
		@(negedge clk_8);
		while (ipl !== exp && n < 40) begin
			@(negedge clk_8);
			n++;
		end
		checks++;
		if (ipl !== exp) begin
			errors++;
			$display("interrupt level never reached %s within 40 cycles", what);
		end
	endtask

	// level sits on a3..a1 of a cpu space cycle
	task automatic acknowledge(input logic [2:0] level, input logic [7:0] exp_vec,
		input logic exp_mfp);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		@(posedge clk_8);
		cpu_fc <= FC_IACK;
		cpu_addr <= {20'hfffff, level};
		cpu_as <= 1'b1;
		while (!seen && n < 40) begin
			@(negedge clk_8);
			if (exp_mfp ? mfp_iack : (auto_vector != 8'h00))
				seen = 1;
			else
				n++;
		end
		checks++;
		if (!seen) begin
			errors++;
			$display("no answer to the interrupt acknowledge at level %0d", level);
		end else begin
			check(auto_vector, exp_vec, "auto_vector");
			check(mfp_iack, exp_mfp, "mfp_iack");
		end
		@(posedge clk_8);
		cpu_as <= 1'b0;
		cpu_fc <= 3'd5;
	endtask

	task automatic run_irq_test;
		pulse_sync(1'b1, 1'b0);
		wait_ipl(IPL_VBI, "vbi");
		acknowledge(3'd4, VEC_VBI, 1'b0);
		wait_ipl(IPL_IDLE, "idle after vbi ack");
		pulse_sync(1'b0, 1'b1);
		wait_ipl(IPL_HBI, "hbi");
		acknowledge(3'd2, VEC_HBI, 1'b0);
		wait_ipl(IPL_IDLE, "idle after hbi ack");
		// vbi outranks a pending hbi
		pulse_sync(1'b1, 1'b1);
		wait_ipl(IPL_VBI, "vbi over hbi");
		// mfp outranks both latched levels
		@(posedge clk_8);
		mfp_irq <= 1'b1;
		wait_ipl(IPL_MFP, "mfp over vbi");
		acknowledge(3'd6, 8'h00, 1'b1);
		@(posedge clk_8);
		mfp_irq <= 1'b0;
		wait_ipl(IPL_VBI, "vbi behind mfp");
		acknowledge(3'd4, VEC_VBI, 1'b0);
		wait_ipl(IPL_HBI, "hbi behind vbi");
		acknowledge(3'd2, VEC_HBI, 1'b0);
		wait_ipl(IPL_IDLE, "idle at the end");
	endtask

	initial begin
		clk_8 = 1'b0;
		pll_locked = 1'b0;
		mem_size = MEM_4M;
		ste = 1'b0;
		mste = 1'b0;
		steroids = 1'b0;
		blitter_en = 1'b0;
		ethernec_en = 1'b0;
		enable_16mhz = 1'b0;
		cpu_addr = '0;
		cpu_rw = 1'b1;
		cpu_fc = 3'd5;
		cpu_as = 1'b0;
		cpu_fast_cycle = 1'b0;
		clr_berr = 1'b0;
		br = 1'b0;
		st_hs = 1'b0;
		st_vs = 1'b0;
		mfp_irq = 1'b0;
		pattern_count = 0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		cycle_limit = 0;
		seed = 32'h96ae;
		read_patterns(file_ok);
		if (!file_ok) begin
			$display("could not read any access from verif/st_bus_patterns.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			// about 8 cycles per access plus reset, slot, berr and irq tests
			cycle_limit = pattern_count * 8 + 400;
			repeat (9) @(posedge clk_8);
			@(negedge clk_8);
			check(dtack, 0, "dtack in reset");
			check(berr, 0, "berr in reset");
			check(mfp_iack, 0, "mfp_iack in reset");
			check(ipl, IPL_IDLE, "ipl in reset");
			check(auto_vector, 0, "auto_vector in reset");
			check(video_cycle, 1, "slot 0 in reset");
			@(posedge clk_8);
			pll_locked <= 1'b1;
			check_slots(8'h03, 1'b0, 2);
			check_slots(8'h23, 1'b0, 4);
			check_slots(8'h13, 1'b1, 4);
			check_slots(8'h13, 1'b0, 2);
			for (int i = 0; i < pattern_count; i++)
				run_pattern(i);
			run_berr_test();
			run_irq_test();
			$display("%0d checks, %0d errors", checks, errors);
			if (errors == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: source/st_bus_top.sv
// bus core top; ram strobes, data muxing and peripherals live outside, dtack lags the sampled address by two clk_8
`default_nettype none
`timescale 1ns/1ns

module st_bus_top (
	input  wire                        clk_8,
	input  wire                        pll_locked,
	// configuration levels
	input  wire st_bus_pkg::mem_size_t mem_size,
	input  wire                        ste,
	input  wire                        mste,
	input  wire                        steroids,
	input  wire                        blitter_en,
	input  wire                        ethernec_en,
	// from the mega ste speed register
	input  wire                        enable_16mhz,
	// cpu bus
	input  wire [23:1]                 cpu_addr,
	input  wire                        cpu_rw,
	input  wire [2:0]                  cpu_fc,
	input  wire                        cpu_as,
	input  wire                        cpu_fast_cycle,
	input  wire                        clr_berr,
	// dma and blitter request level
	input  wire                        br,
	// interrupt sources
	input  wire                        st_hs,
	input  wire                        st_vs,
	input  wire                        mfp_irq,
	output logic                       cpu_cycle,
	output logic                       video_cycle,
	output st_bus_pkg::region_t        region,
	output st_bus_pkg::io_dev_t        io_dev,
	output logic                       cpu2mem,
	output logic                       dtack,
	output logic                       berr,
	output logic [2:0]                 ipl,
	output logic [7:0]                 auto_vector,
	output logic                       mfp_iack
);

	logic       second_cpu_slot;
	logic       iack_cycle;
	logic [2:0] ack_level;

	// steroids always runs at full speed
	assign second_cpu_slot = (enable_16mhz && mste) || steroids;

	// slot number and cpu2ram drive the ram multiplexer outside this core
	bus_slot_sequencer u_bus_slot_sequencer (
		.clk_8           (clk_8),
		.pll_locked      (pll_locked),
		.second_cpu_slot (second_cpu_slot),
		.slot            (),
		.cpu_cycle       (cpu_cycle),
		.video_cycle     (video_cycle)
	);

	address_decoder u_address_decoder (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cpu_addr    (cpu_addr),
		.cpu_rw      (cpu_rw),
		.cpu_fc      (cpu_fc),
		.mem_size    (mem_size),
		.ste         (ste),
		.mste        (mste),
		.steroids    (steroids),
		.blitter_en  (blitter_en),
		.ethernec_en (ethernec_en),
		.region      (region),
		.io_dev      (io_dev),
		.cpu2mem     (cpu2mem),
		.cpu2ram     (),
		.iack_cycle  (iack_cycle),
		.ack_level   (ack_level)
	);

	bus_monitor u_bus_monitor (
		.clk_8          (clk_8),
		.pll_locked     (pll_locked),
		.cpu2mem        (cpu2mem),
		.io_dev         (io_dev),
		.cpu_cycle      (cpu_cycle),
		.cpu_as         (cpu_as),
		.br             (br),
		.cpu_fast_cycle (cpu_fast_cycle),
		.clr_berr       (clr_berr),
		.dtack          (dtack),
		.berr           (berr)
	);

	irq_controller u_irq_controller (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.st_hs       (st_hs),
		.st_vs       (st_vs),
		.mfp_irq     (mfp_irq),
		.iack_cycle  (iack_cycle),
		.ack_level   (ack_level),
		.cpu_cycle   (cpu_cycle),
		.cpu_as      (cpu_as),
		.ipl         (ipl),
		.auto_vector (auto_vector),
		.mfp_iack    (mfp_iack)
	);

endmodule

`default_nettype wire

// File: source/irq_controller.sv
// st_vs and st_hs are async and must be high for at least one clk_8; mfp_irq is a level taken as is
`default_nettype none
`timescale 1ns/1ns

module irq_controller (
	input  wire        clk_8,
	input  wire        pll_locked,
	input  wire        st_hs,
	input  wire        st_vs,
	input  wire        mfp_irq,
	input  wire        iack_cycle,
	input  wire [2:0]  ack_level,
	input  wire        cpu_cycle,
	input  wire        cpu_as,
	output logic [2:0] ipl,
	output logic [7:0] auto_vector,
	output logic       mfp_iack
);

	import st_bus_pkg::*;

	logic vs_d1, vs_d2, hs_d1, hs_d2;
	logic vbi, hbi;
	logic iack_slot, vbi_ack, hbi_ack, mfp_ack;

	assign iack_slot = iack_cycle && cpu_cycle && cpu_as;

	// acknowledged level is the complement of its active low ipl code
	assign vbi_ack = iack_slot && (ack_level == ~IPL_VBI);
	assign hbi_ack = iack_slot && (ack_level == ~IPL_HBI);
	assign mfp_ack = iack_slot && (ack_level == ~IPL_MFP);

	// sync edge detect, latch until acked
	// an ack wins over a new edge in the same cycle
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
			hs_d1 <= 1'b0;
			hs_d2 <= 1'b0;
			vbi   <= 1'b0;
			hbi   <= 1'b0;
		end else begin
			vs_d1 <= st_vs;
			vs_d2 <= vs_d1;
			hs_d1 <= st_hs;
			hs_d2 <= hs_d1;
			if (vbi_ack)
				vbi <= 1'b0;
			else if (vs_d1 && !vs_d2)
				vbi <= 1'b1;
			if (hbi_ack)
				hbi <= 1'b0;
			else if (hs_d1 && !hs_d2)
				hbi <= 1'b1;
		end
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			ipl         <= IPL_IDLE;
			auto_vector <= 8'h00;
			mfp_iack    <= 1'b0;
		end else begin
			// mfp level 6, vbi level 4, hbi level 2
			if (mfp_irq)
				ipl <= IPL_MFP;
			else if (vbi)
				ipl <= IPL_VBI;
			else if (hbi)
				ipl <= IPL_HBI;
			else
				ipl <= IPL_IDLE;
			// vectored answers for the st autovector levels
			if (vbi_ack)
				auto_vector <= VEC_VBI;
			else if (hbi_ack)
				auto_vector <= VEC_HBI;
			else
				auto_vector <= 8'h00;
			// the mfp supplies its own vector
			mfp_iack <= mfp_ack;
		end
	end

endmodule

`default_nettype wire

// File: source/bus_monitor.sv
// dtack and bus error for the decoded access; berr stays set until clr_berr, io without a device never acks
`default_nettype none
`timescale 1ns/1ns

module bus_monitor (
	input  wire                      clk_8,
	input  wire                      pll_locked,
	input  wire                      cpu2mem,
	input  wire st_bus_pkg::io_dev_t io_dev,
	input  wire                      cpu_cycle,
	input  wire                      cpu_as,
	// another master owns the bus
	input  wire                      br,
	// cpu runs from cache, no bus access expected
	input  wire                      cpu_fast_cycle,
	// one cycle pulse once the cpu has taken the exception
	input  wire                      clr_berr,
	output logic                     dtack,
	output logic                     berr
);

	import st_bus_pkg::*;

	logic [3:0] timeout_cnt;
	logic       dtack_d;
	logic       bus_ok;

	// memory or an implemented io device answers in the cpu slot
	// bus request suppresses dtack, which stalls the cpu
	assign dtack_d = !br && cpu_cycle && cpu_as &&
		(cpu2mem || (io_dev != DEV_NONE));

	// any of these means the cpu is not waiting on a dead address
	assign bus_ok = dtack_d || br || cpu2mem || cpu_fast_cycle;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			dtack <= 1'b0;
		else
			dtack <= dtack_d;
	end

	// counts cpu slots without an answer
	// saturates at the limit so berr holds
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout_cnt <= 4'd0;
		end else if (clr_berr) begin
			timeout_cnt <= 4'd0;
		end else if (cpu_cycle && !berr) begin
			if (bus_ok)
				timeout_cnt <= 4'd0;
			else if (cpu_as)
				timeout_cnt <= timeout_cnt + 4'd1;
		end
	end

	// rom writes and unmapped io end up here
	assign berr = (timeout_cnt == BERR_LIMIT);

endmodule

`default_nettype wire

// File: source/address_decoder.sv
// two stage decode, inputs latched every clk_8 and decoded the next; no stall, config levels sampled with the address
`default_nettype none
`timescale 1ns/1ns

module address_decoder (
	input  wire                        clk_8,
	input  wire                        pll_locked,
	// word address, bit 0 does not exist on the 68000 bus
	input  wire [23:1]                 cpu_addr,
	input  wire                        cpu_rw,
	input  wire [2:0]                  cpu_fc,
	input  wire st_bus_pkg::mem_size_t mem_size,
	input  wire                        ste,
	input  wire                        mste,
	input  wire                        steroids,
	input  wire                        blitter_en,
	input  wire                        ethernec_en,
	output st_bus_pkg::region_t        region,
	output st_bus_pkg::io_dev_t        io_dev,
	output logic                       cpu2mem,
	output logic                       cpu2ram,
	output logic                       iack_cycle,
	output logic [2:0]                 ack_level
);

	import st_bus_pkg::*;

	logic [23:1] addr_q;
	logic        rw_q;
	logic [2:0]  fc_q;
	mem_size_t   mem_size_q;
	logic        ste_q, mste_q, steroids_q, blitter_en_q, ethernec_q;

	logic [23:0] byte_addr;
	logic        big_ram, lowrom, ram, tos192, tos256, cart_win, rom;
	logic        mste_io;
	region_t     region_d;
	io_dev_t     io_dev_d;

	// true when a matches base in all bits above span
	function automatic logic in_win(input logic [23:0] a, input logic [23:0] base,
		input int unsigned span);
		in_win = ((a ^ base) >> span) == 24'd0;
	endfunction

	// stage 1, latch the cpu bus and the configuration levels
	always_ff @(posedge clk_8) begin
		addr_q       <= cpu_addr;
		rw_q         <= cpu_rw;
		fc_q         <= cpu_fc;
		mem_size_q   <= mem_size;
		ste_q        <= ste;
		mste_q       <= mste;
		steroids_q   <= steroids;
		blitter_en_q <= blitter_en;
		ethernec_q   <= ethernec_en;
	end

	assign byte_addr = {addr_q, 1'b0};

	// rom is mirrored into the first 8 bytes for the reset vectors
	assign lowrom = in_win(byte_addr, BASE_LOWROM, SPAN_LOWROM);

	// 8M and 14M both extend ram past the first 4M
	assign big_ram = (mem_size_q == MEM_8M) || (mem_size_q == MEM_14M);
	assign ram = !lowrom && (in_win(byte_addr, BASE_RAM_4M, SPAN_RAM_4M) ||
		(big_ram && in_win(byte_addr, BASE_RAM_8M, SPAN_RAM_4M)) ||
		((mem_size_q == MEM_14M) && (in_win(byte_addr, BASE_RAM_12M, SPAN_RAM_4M) ||
			in_win(byte_addr, BASE_RAM_14M, SPAN_RAM_14M))) ||
		(steroids_q && in_win(byte_addr, BASE_RAM_ALT, SPAN_RAM_ALT)));

	assign tos256 = in_win(byte_addr, BASE_TOS256, SPAN_TOS256);
	assign tos192 = (byte_addr >= BASE_TOS192) && (byte_addr < BASE_IO);

	// the cartridge port doubles as romport for the ethernec card
	assign cart_win = in_win(byte_addr, BASE_CART, SPAN_CART);
	assign rom = lowrom || tos192 || tos256 || (cart_win && !ethernec_q);

	// mega ste registers, steroids has no cache or speed control
	assign mste_io = mste_q && !steroids_q;

	always_comb begin
		if (lowrom)
			region_d = REG_LOWROM;
		else if (ram)
			region_d = REG_RAM;
		else if (tos256)
			region_d = REG_TOS256;
		else if (tos192)
			region_d = REG_TOS192;
		else if (cart_win && !ethernec_q)
			region_d = REG_CART;
		else if (in_win(byte_addr, BASE_IO, SPAN_IO))
			region_d = REG_IO;
		else
			region_d = REG_NONE;
	end

	// windows do not overlap, order only matters for readability
	always_comb begin
		io_dev_d = DEV_NONE;
		if (cart_win && ethernec_q && rw_q)
			io_dev_d = DEV_ROMPORT;
		else if (in_win(byte_addr, WIN_MMU, SPAN_MMU))
			io_dev_d = DEV_MMU;
		else if (in_win(byte_addr, WIN_VIDEO, SPAN_VIDEO))
			io_dev_d = DEV_VIDEO;
		else if (in_win(byte_addr, WIN_DMA, SPAN_DMA))
			io_dev_d = DEV_DMA;
		else if (in_win(byte_addr, WIN_PSG, SPAN_PSG))
			io_dev_d = DEV_PSG;
		else if (ste_q && in_win(byte_addr, WIN_STE_SND, SPAN_STE_SND))
			io_dev_d = DEV_STE_SND;
		// an ste always has a blitter
		else if ((blitter_en_q || ste_q) && in_win(byte_addr, WIN_BLITTER, SPAN_BLITTER))
			io_dev_d = DEV_BLITTER;
		else if (mste_io && in_win(byte_addr, WIN_VME, SPAN_VME))
			io_dev_d = DEV_VME;
		else if (mste_io && in_win(byte_addr, WIN_MSTE_CTRL, SPAN_MSTE))
			io_dev_d = DEV_MSTE_CTRL;
		else if (ste_q && in_win(byte_addr, WIN_STE_JOY, SPAN_STE_JOY))
			io_dev_d = DEV_STE_JOY;
		else if (in_win(byte_addr, WIN_MFP, SPAN_MFP))
			io_dev_d = DEV_MFP;
		else if (in_win(byte_addr, WIN_ACIA, SPAN_ACIA))
			io_dev_d = DEV_ACIA;
	end

	// stage 2, one decoded access per cycle
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			region     <= REG_NONE;
			io_dev     <= DEV_NONE;
			cpu2mem    <= 1'b0;
			cpu2ram    <= 1'b0;
			iack_cycle <= 1'b0;
		end else begin
			region     <= region_d;
			io_dev     <= io_dev_d;
			// ram both ways, rom only on read
			cpu2mem    <= ram || (rw_q && rom);
			cpu2ram    <= ram;
			iack_cycle <= (fc_q == FC_IACK);
		end
	end

	// level being acknowledged sits on a3..a1 during iack
	always_ff @(posedge clk_8) begin
		ack_level <= addr_q[3:1];
	end

endmodule

`default_nettype wire

// File: source/bus_slot_sequencer.sv
// free running slot counter on clk_8; second_cpu_slot may change at any time and takes effect at once
`default_nettype none
`timescale 1ns/1ns

module bus_slot_sequencer (
	input  wire               clk_8,
	input  wire               pll_locked,
	// enables the cpu slot 3 for 16 MHz like operation
	input  wire               second_cpu_slot,
	output st_bus_pkg::slot_t slot,
	output logic              cpu_cycle,
	output logic              video_cycle
);

	import st_bus_pkg::*;

	// slot 0 video, 1 cpu, 2 spare, 3 spare or second cpu
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= VIDEO_SLOT;
		end else begin
			// wraps from 3 back to the video slot
			slot <= slot + 2'd1;
		end
	end

	// video and ste dma sound share this slot
	assign video_cycle = (slot == VIDEO_SLOT);

	// cpu, dma and blitter share the cpu slots
	assign cpu_cycle = (slot == CPU_SLOT) ||
		(second_cpu_slot && (slot == CPU_SLOT_2));

endmodule

`default_nettype wire

// File: source/st_bus_pkg.sv
// shared types and constants of the 8 MHz bus core; addresses are 24-bit byte addresses, ipl codes are active low
`default_nettype none

package st_bus_pkg;

	// four bus slots per memory cycle
	typedef logic [1:0] slot_t;

	localparam slot_t VIDEO_SLOT = 2'd0;
	localparam slot_t CPU_SLOT   = 2'd1;
	// only used in mega ste 16 MHz or steroids mode
	localparam slot_t CPU_SLOT_2 = 2'd3;

	// configured ram size, same encoding as the system control word
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_t;

	typedef enum logic [2:0] {
		REG_NONE,
		REG_RAM,
		REG_LOWROM,
		REG_TOS192,
		REG_TOS256,
		REG_CART,
		REG_IO
	} region_t;

	typedef enum logic [3:0] {
		DEV_NONE,
		DEV_MMU,
		DEV_VIDEO,
		DEV_DMA,
		DEV_PSG,
		DEV_STE_SND,
		DEV_BLITTER,
		DEV_VME,
		DEV_MSTE_CTRL,
		DEV_STE_JOY,
		DEV_MFP,
		DEV_ACIA,
		DEV_ROMPORT
	} io_dev_t;

	// memory regions, base and number of don't care low bits
	localparam logic [23:0] BASE_LOWROM  = 24'h000000;
	localparam int unsigned SPAN_LOWROM  = 3;
	localparam logic [23:0] BASE_RAM_4M  = 24'h000000;
	localparam logic [23:0] BASE_RAM_8M  = 24'h400000;
	localparam logic [23:0] BASE_RAM_12M = 24'h800000;
	localparam int unsigned SPAN_RAM_4M  = 22;
	localparam logic [23:0] BASE_RAM_14M = 24'hc00000;
	localparam int unsigned SPAN_RAM_14M = 21;
	// extra 512k of fast ram for steroids
	localparam logic [23:0] BASE_RAM_ALT = 24'he80000;
	localparam int unsigned SPAN_RAM_ALT = 19;
	localparam logic [23:0] BASE_TOS256  = 24'he00000;
	localparam int unsigned SPAN_TOS256  = 18;
	// tos192 runs from here up to the io page
	localparam logic [23:0] BASE_TOS192  = 24'hfc0000;
	localparam logic [23:0] BASE_CART    = 24'hfa0000;
	localparam int unsigned SPAN_CART    = 17;
	localparam logic [23:0] BASE_IO      = 24'hff0000;
	localparam int unsigned SPAN_IO      = 16;

	// io register windows
	localparam logic [23:0] WIN_MMU       = 24'hff8000;
	localparam int unsigned SPAN_MMU      = 1;
	localparam logic [23:0] WIN_VIDEO     = 24'hff8200;
	localparam int unsigned SPAN_VIDEO    = 7;
	localparam logic [23:0] WIN_DMA       = 24'hff8600;
	localparam int unsigned SPAN_DMA      = 4;
	localparam logic [23:0] WIN_PSG       = 24'hff8800;
	localparam int unsigned SPAN_PSG      = 8;
	localparam logic [23:0] WIN_STE_SND   = 24'hff8900;
	localparam int unsigned SPAN_STE_SND  = 6;
	localparam logic [23:0] WIN_BLITTER   = 24'hff8a00;
	localparam int unsigned SPAN_BLITTER  = 8;
	localparam logic [23:0] WIN_VME       = 24'hff8e00;
	localparam int unsigned SPAN_VME      = 4;
	localparam logic [23:0] WIN_MSTE_CTRL = 24'hff8e20;
	localparam int unsigned SPAN_MSTE     = 1;
	localparam logic [23:0] WIN_STE_JOY   = 24'hff9200;
	localparam int unsigned SPAN_STE_JOY  = 6;
	localparam logic [23:0] WIN_MFP       = 24'hfffa00;
	localparam int unsigned SPAN_MFP      = 6;
	localparam logic [23:0] WIN_ACIA      = 24'hfffc00;
	localparam int unsigned SPAN_ACIA     = 8;

	// cpu space function code
	localparam logic [2:0] FC_IACK = 3'b111;

	// ipl[0] is tied high on the st
	localparam logic [2:0] IPL_MFP  = 3'b001;
	localparam logic [2:0] IPL_VBI  = 3'b011;
	localparam logic [2:0] IPL_HBI  = 3'b101;
	localparam logic [2:0] IPL_IDLE = 3'b111;

	// vectors handed out for the st autovector levels
	localparam logic [7:0] VEC_VBI = 8'h1c;
	localparam logic [7:0] VEC_HBI = 8'h1a;

	localparam logic [3:0] BERR_LIMIT = 4'd15;

endpackage

`default_nettype wire
